//--- design/spi_bridge_defines.svh
`ifndef SPI_BRIDGE_DEFINES_SVH
`define SPI_BRIDGE_DEFINES_SVH

// SPI word and data path width.
`define WORD_W 16

// word RAM address width, 256 words.
`define RAM_AW 8

// clk_50MHz cycles per display digit step (1 kHz scan).
`define SCAN_DIV 50000

// answer to the identification opcode.
`define ID_WORD 16'h1234

`endif

//--- design/spi_bridge_pkg.sv
`default_nettype none

`include "spi_bridge_defines.svh"

package spi_bridge_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    // high byte of a command word.
    typedef enum logic [7:0] {
        op_display = 8'h20,
        op_ident   = 8'h30,
        op_read    = 8'hC0,
        op_write   = 8'hC1
    } cmd_opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_rd_addr,
        st_rd_wait,
        st_wr_addr,
        st_wr_data,
        st_disp_data
    } dec_state_e;

    typedef struct packed {
        logic  valid;
        word_t data;
    } rx_word_t;

    typedef struct packed {
        logic              en;
        logic              we;
        logic [`RAM_AW-1:0] addr;
        word_t             wdata;
    } ram_req_t;

    typedef logic [7:0] seg_t;     // a..g in bits 0..6, dp in bit 7, active low.
    typedef logic [3:0] dig_sel_t; // active low.

endpackage

`default_nettype wire

//--- design/spi_word_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_defines.svh"

module spi_word_slave (
    input  logic                     clk_50MHz,
    input  logic                     reset,
    input  logic                     spi_sck_i,
    input  logic                     spi_cs_i,
    input  logic                     spi_mosi_i,
    output logic                     spi_miso_o,
    input  spi_bridge_pkg::word_t    resp_word_i,
    output spi_bridge_pkg::rx_word_t rx_o
);
    import spi_bridge_pkg::*;

    localparam int CNT_W = $clog2(`WORD_W);

    logic [2:0]       sck_q;
    logic [2:0]       cs_q;
    logic [1:0]       mosi_q;
    logic             sck_rise;
    logic             sck_fall;
    logic             cs_fall;
    logic             cs_active;
    logic [CNT_W-1:0] bit_cnt;
    logic             rx_valid;
    word_t            rx_shift;
    word_t            tx_shift;

    // two flops for metastability, the third one for edge detection.
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            sck_q <= '0;
            cs_q  <= '1;
        end else begin
            sck_q <= {sck_q[1:0], spi_sck_i};
            cs_q  <= {cs_q[1:0], spi_cs_i};
        end
    end

    always_ff @(posedge clk_50MHz) begin
        mosi_q <= {mosi_q[0], spi_mosi_i}; // same depth as sck.
    end

    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign sck_fall  = ~sck_q[1] & sck_q[2];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    assign cs_active = ~cs_q[1];

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`WORD_W - 1))
                    rx_valid <= 1'b1; // last bit lands this cycle.
            end
        end
    end

    // msb first.
    always_ff @(posedge clk_50MHz) begin
        if (cs_active && sck_rise)
            rx_shift <= {rx_shift[`WORD_W-2:0], mosi_q[1]};
    end

    assign rx_o = '{valid: rx_valid, data: rx_shift};

    // response is taken at the start of the transfer.
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            tx_shift <= '0;
        end else if (cs_fall) begin
            tx_shift <= resp_word_i;
        end else if (cs_active && sck_fall) begin
            tx_shift <= {tx_shift[`WORD_W-2:0], 1'b0};
        end
    end

    assign spi_miso_o = tx_shift[`WORD_W-1];

endmodule

`default_nettype wire

//--- design/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_defines.svh"

module cmd_decoder (
    input  logic                     clk_50MHz,
    input  logic                     reset,
    input  spi_bridge_pkg::rx_word_t rx_i,
    output spi_bridge_pkg::ram_req_t ram_req_o,
    input  spi_bridge_pkg::word_t    ram_rdata_i,
    output spi_bridge_pkg::word_t    resp_word_o,
    output spi_bridge_pkg::word_t    disp_value_o
);
    import spi_bridge_pkg::*;

    dec_state_e  state;
    cmd_opcode_e opcode;

    assign opcode = cmd_opcode_e'(rx_i.data[`WORD_W-1 -: 8]);

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            state        <= st_idle;
            resp_word_o  <= '0;
            disp_value_o <= '0;
            ram_req_o.en <= 1'b0;
            ram_req_o.we <= 1'b0;
        end else begin
            ram_req_o.en <= 1'b0; // requests last a single cycle.
            ram_req_o.we <= 1'b0;

            case (state)
                st_idle: begin
                    if (rx_i.valid) begin
                        case (opcode)
                            op_read:    state <= st_rd_addr;
                            op_write:   state <= st_wr_addr;
                            op_display: state <= st_disp_data;
                            op_ident:   resp_word_o <= `ID_WORD;
                            default: begin
                                // unknown opcode, stay idle.
                            end
                        endcase
                    end
                end

                st_rd_addr: begin
                    if (rx_i.valid) begin
                        ram_req_o.en   <= 1'b1;
                        ram_req_o.addr <= rx_i.data[`RAM_AW-1:0];
                        state          <= st_rd_wait;
                    end
                end

                // first cycle carries the request, data is back in the second.
                st_rd_wait: begin
                    if (!ram_req_o.en) begin
                        resp_word_o <= ram_rdata_i;
                        state       <= st_idle;
                    end
                end

                st_wr_addr: begin
                    if (rx_i.valid) begin
                        ram_req_o.addr <= rx_i.data[`RAM_AW-1:0]; // held until the data word.
                        state          <= st_wr_data;
                    end
                end

                st_wr_data: begin
                    if (rx_i.valid) begin
                        ram_req_o.en    <= 1'b1;
                        ram_req_o.we    <= 1'b1;
                        ram_req_o.wdata <= rx_i.data;
                        state           <= st_idle;
                    end
                end

                st_disp_data: begin
                    if (rx_i.valid) begin
                        disp_value_o <= rx_i.data;
                        state        <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_defines.svh"

module word_ram (
    input  logic                     clk_50MHz,
    input  spi_bridge_pkg::ram_req_t req_i,
    output spi_bridge_pkg::word_t    rdata_o
);
    import spi_bridge_pkg::*;

    localparam int DEPTH = 2 ** `RAM_AW;

    word_t mem [DEPTH];

    // single port, read data one cycle after the request.
    always_ff @(posedge clk_50MHz) begin
        if (req_i.en) begin
            if (req_i.we)
                mem[req_i.addr] <= req_i.wdata;
            else
                rdata_o <= mem[req_i.addr];
        end
    end

endmodule

`default_nettype wire

//--- design/tube_scanner.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_defines.svh"

module tube_scanner (
    input  logic                     clk_50MHz,
    input  logic                     reset,
    input  spi_bridge_pkg::word_t    value_i,
    output spi_bridge_pkg::seg_t     seg_o,
    output spi_bridge_pkg::dig_sel_t dig_o
);
    import spi_bridge_pkg::*;

    localparam int DIV_W = $clog2(`SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       dig_idx;
    logic [3:0]       nibble;

    // hex digit to segments, gfedcba active high.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            div_cnt <= '0;
            dig_idx <= '0;
        end else if (div_cnt == DIV_W'(`SCAN_DIV - 1)) begin
            div_cnt <= '0;
            dig_idx <= dig_idx + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble = value_i[{dig_idx, 2'b00} +: 4]; // digit 0 is the low nibble.

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            seg_o <= '1;
            dig_o <= '1; // all digits dark.
        end else begin
            seg_o <= {1'b1, ~hex_to_seg(nibble)}; // dp stays off.
            dig_o <= ~(dig_sel_t'(1) << dig_idx);
        end
    end

endmodule

`default_nettype wire

//--- design/spi_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module spi_bridge_top (
    input  logic                     clk_50MHz,
    input  logic                     reset,
    input  logic                     spi_sck_i,
    input  logic                     spi_cs_i,
    input  logic                     spi_mosi_i,
    output logic                     spi_miso_o,
    output spi_bridge_pkg::seg_t     seg_o,
    output spi_bridge_pkg::dig_sel_t dig_o
);
    import spi_bridge_pkg::*;

    rx_word_t rx_word;
    word_t    resp_word;
    ram_req_t ram_req;
    word_t    ram_rdata;
    word_t    disp_value;

    spi_word_slave spi_word_slave_inst (
        .clk_50MHz   (clk_50MHz),
        .reset       (reset),
        .spi_sck_i   (spi_sck_i),
        .spi_cs_i    (spi_cs_i),
        .spi_mosi_i  (spi_mosi_i),
        .spi_miso_o  (spi_miso_o),
        .resp_word_i (resp_word),
        .rx_o        (rx_word)
    );

    cmd_decoder cmd_decoder_inst (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .rx_i         (rx_word),
        .ram_req_o    (ram_req),
        .ram_rdata_i  (ram_rdata),
        .resp_word_o  (resp_word),
        .disp_value_o (disp_value)
    );

    word_ram word_ram_inst (
        .clk_50MHz (clk_50MHz),
        .req_i     (ram_req),
        .rdata_o   (ram_rdata)
    );

    tube_scanner tube_scanner_inst (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .value_i   (disp_value),
        .seg_o     (seg_o),
        .dig_o     (dig_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_spi_bridge.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_defines.svh"

module tb_spi_bridge;
    import spi_bridge_pkg::*;

    localparam int HALF_SCK    = 4; // clk_50MHz cycles per sck half period.
    localparam int IDLE_CYCLES = 10;
    localparam int N_PAIRS     = 8;
    localparam int N_RANDOM    = 200;
    localparam int XFER_CYCLES = 1 + 2 * HALF_SCK * (`WORD_W + 1) + IDLE_CYCLES;
    localparam int MAX_XFERS   = 1 + 6 * N_PAIRS + 6 + 3 * N_RANDOM + 1;
    localparam int SCAN_CYCLES = 4 * `SCAN_DIV + 2;
    localparam int TEST_CYCLES = 10 + MAX_XFERS * XFER_CYCLES + 8 * `SCAN_DIV
                               + 4 * (SCAN_CYCLES + 1);

    // common anode patterns, dp in bit 7.
    localparam seg_t SEG_PATTERN [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82,
        8'hF8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
    localparam dig_sel_t DIG_PATTERN [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

    logic     clk_50MHz;
    logic     reset;
    logic     spi_sck;
    logic     spi_cs;
    logic     spi_mosi;
    logic     spi_miso;
    seg_t     seg;
    dig_sel_t dig;

    logic [31:0]        lcg_state;
    word_t              model_ram [logic [`RAM_AW-1:0]];
    logic [`RAM_AW-1:0] written_q [$];
    word_t              model_resp;
    word_t              model_disp;

    spi_bridge_top uut (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .spi_sck_i  (spi_sck),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .seg_o      (seg),
        .dig_o      (dig)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16]; // low bits of an lcg repeat too fast.
    endfunction

    function automatic int rand_below(input int n);
        word_t r;
        r = rand_word();
        return int'(r) % n;
    endfunction

    function automatic logic [`RAM_AW-1:0] pick_written();
        return written_q[rand_below(written_q.size())];
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic check_seg(input string test, input seg_t exp_seg, input dig_sel_t exp_dig,
                             input seg_t act_seg, input dig_sel_t act_dig);
        if (exp_seg !== act_seg || exp_dig !== act_dig) begin
            $display("[ERROR] %s: expected seg %h dig %b, actual seg %h dig %b",
                     test, exp_seg, exp_dig, act_seg, act_dig);
            abort_run();
        end
    endtask

    // mode 0, msb first; miso is read just before each rising sck.
    task automatic spi_xfer(input word_t tx, output word_t rx);
        int i;
        @(posedge clk_50MHz);
        spi_cs <= 1'b0;
        repeat (HALF_SCK) @(posedge clk_50MHz);
        for (i = `WORD_W - 1; i >= 0; i--) begin
            spi_mosi <= tx[i];
            repeat (HALF_SCK) @(posedge clk_50MHz);
            rx[i] = spi_miso;
            spi_sck <= 1'b1;
            repeat (HALF_SCK) @(posedge clk_50MHz);
            spi_sck <= 1'b0;
        end
        repeat (HALF_SCK) @(posedge clk_50MHz);
        spi_cs <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk_50MHz);
    endtask

    // every transfer returns the response held when it starts.
    task automatic xfer_check(input string test, input word_t tx);
        word_t rx;
        spi_xfer(tx, rx);
        check_word(test, model_resp, rx);
    endtask

    task automatic send_opcode(input string test, input cmd_opcode_e op);
        word_t w;
        w = rand_word();
        w[`WORD_W-1 -: 8] = op;
        xfer_check(test, w);
    endtask

    task automatic send_address(input string test, input logic [`RAM_AW-1:0] addr);
        word_t w;
        w = rand_word();
        w[`RAM_AW-1:0] = addr; // upper bits are don't care.
        xfer_check(test, w);
    endtask

    task automatic cmd_write(input string test, input logic [`RAM_AW-1:0] addr,
                             input word_t data);
        send_opcode(test, op_write);
        send_address(test, addr);
        xfer_check(test, data);
        if (!model_ram.exists(addr))
            written_q.push_back(addr);
        model_ram[addr] = data;
    endtask

    task automatic cmd_read(input string test, input logic [`RAM_AW-1:0] addr);
        send_opcode(test, op_read);
        send_address(test, addr);
        model_resp = model_ram[addr];
    endtask

    task automatic cmd_display(input string test, input word_t value);
        send_opcode(test, op_display);
        xfer_check(test, value);
        model_disp = value;
    endtask

    task automatic cmd_undefined(input string test);
        word_t w;
        w = rand_word();
        while (w[`WORD_W-1 -: 8] inside {op_read, op_write, op_display, op_ident})
            w = rand_word();
        xfer_check(test, w);
    endtask

    task automatic check_display(input string test, input word_t value);
        int         n;
        int         j;
        int         k;
        int         exp_k;
        int         run;
        logic       locked;
        logic [3:0] seen;
        seen   = '0;
        exp_k  = -1;
        run    = 0;
        locked = 1'b0;
        for (n = 0; n < SCAN_CYCLES; n++) begin
            @(negedge clk_50MHz);
            if (locked) begin
                run++;
                if (run == `SCAN_DIV) begin
                    exp_k = (exp_k + 1) % 4;
                    run   = 0;
                end
            end else begin
                k = -1;
                for (j = 0; j < 4; j++)
                    if (dig == DIG_PATTERN[j])
                        k = j;
                if (k < 0) begin
                    $display("%s: dig_o %b does not select exactly one digit", test, dig);
                    abort_run();
                end
                if (exp_k >= 0 && k != exp_k) begin
                    if (k != (exp_k + 1) % 4) begin
                        $display("%s: digit %0d came after digit %0d, out of scan order",
                                 test, k, exp_k);
                        abort_run();
                    end
                    locked = 1'b1; // later steps follow the scan period.
                end
                exp_k = k;
            end
            check_seg(test, SEG_PATTERN[value[4 * exp_k +: 4]], DIG_PATTERN[exp_k], seg, dig);
            seen[exp_k] = 1'b1;
        end
        if (seen != 4'b1111) begin
            $display("%s: only digits %b were scanned", test, seen);
            abort_run();
        end
        @(posedge clk_50MHz);
    endtask

    initial begin
        int                 i;
        logic [`RAM_AW-1:0] addr;
        word_t              w;
        reset      = 1'b1;
        spi_sck    = 1'b0;
        spi_cs     = 1'b1;
        spi_mosi   = 1'b0;
        lcg_state  = 32'd23183;
        model_resp = '0;
        model_disp = '0;
        repeat (10) @(posedge clk_50MHz);
        reset <= 1'b0;
        @(posedge clk_50MHz); // outputs leave their reset values here.

        check_display("reset display", model_disp);
        cmd_undefined("reset response");

        for (i = 0; i < N_PAIRS; i++) begin
            if (i < N_PAIRS / 2) begin
                w    = rand_word();
                addr = w[`RAM_AW-1:0];
            end else begin
                addr = pick_written(); // overwrite.
            end
            cmd_write("write then read", addr, rand_word());
            cmd_read("write then read", addr);
            cmd_undefined("write then read");
        end

        send_opcode("ident", op_ident);
        model_resp = `ID_WORD;
        cmd_undefined("ident");

        cmd_display("display", rand_word());
        repeat (8 * `SCAN_DIV) @(posedge clk_50MHz);
        check_display("display", model_disp);

        cmd_undefined("undefined opcode");
        cmd_undefined("undefined opcode");
        check_display("undefined opcode display", model_disp);

        for (i = 0; i < N_RANDOM; i++) begin
            case (rand_below(5))
                0: cmd_read("random read", pick_written());
                1: begin
                    w = rand_word();
                    cmd_write("random write", w[`RAM_AW-1:0], rand_word());
                end
                2: cmd_display("random display", rand_word());
                3: begin
                    send_opcode("random ident", op_ident);
                    model_resp = `ID_WORD;
                end
                default: cmd_undefined("random undefined");
            endcase
        end
        cmd_undefined("random final response");
        check_display("random final display", model_disp);

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        repeat (2 * TEST_CYCLES) @(posedge clk_50MHz);
        $display("timeout: the tests did not finish within %0d clock cycles", 2 * TEST_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/spi_bridge_pkg.sv
design/spi_word_slave.sv
design/cmd_decoder.sv
design/word_ram.sv
design/tube_scanner.sv
design/spi_bridge_top.sv
tests/tb_spi_bridge.sv

//--- Makefile
# Verilator flow for the SPI bridge.
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_spi_bridge
RTL_TOP    ?= spi_bridge_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST RESULT: PASS
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing
RTL_FILES  ?= $(shell grep '^design/' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) +incdir+design $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
